// File: include/i2c_bank_defs.svh
`ifndef I2C_BANK_DEFS_SVH
`define I2C_BANK_DEFS_SVH

// Number of I2C channels in the bank.
`define I2C_CHANNELS 4

// Width of a channel index, at least one bit.
`define I2C_CHAN_W ((`I2C_CHANNELS > 1) ? $clog2(`I2C_CHANNELS) : 1)

// Wishbone bus widths.
`define WB_DATA_W 32
`define WB_ADR_W 5

// Prescaler width and value after reset.
`define I2C_PRESCALE_W 16
`define I2C_PRESCALE_RESET 2

`endif

// File: list.f
+incdir+include
src/wb_reg_pkg.sv
src/i2c_line_pkg.sv
src/reg_access_if.sv
src/wb_slave_decode.sv
src/i2c_channel_regs.sv
src/i2c_byte_engine.sv
src/i2c_bank_top.sv
verif/tb_clock_gen.sv
verif/i2c_bank_assert.sv
verif/i2c_bank_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the I2C bank testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module i2c_bank_tb \
        --Mdir obj_dir -o i2c_bank_sim > build.log 2>&1 \
        && ./obj_dir/i2c_bank_sim > sim.log 2>&1 \
        || echo "build or run returned an error"
grep -qx "Everything OK" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src/i2c_bank_top.sv
`default_nettype none
`include "i2c_bank_defs.svh"

module i2c_bank_top (
        input  wire                     wb_clk_i,
        input  wire                     rst_n,
        input  wire                     wb_cyc_i,
        input  wire                     wb_we_i,
        input  wire [`I2C_CHANNELS-1:0] wb_stb_i,
        input  wire [`WB_ADR_W-1:0]     wb_adr_i,
        input  wire [`WB_DATA_W-1:0]    wb_dat_i,
        output wire [`WB_DATA_W-1:0]    wb_dat_o,
        output wire                     wb_ack_o,
        output wire [`I2C_CHANNELS-1:0] wb_int_o,
        output wire [`I2C_CHANNELS-1:0] scl,
        output wire [`I2C_CHANNELS-1:0] sclen,
        output wire [`I2C_CHANNELS-1:0] sda_out,
        input  wire [`I2C_CHANNELS-1:0] sda_in
);

        reg_access_if acc ();

        wb_slave_decode i_wb_slave_decode (
                .wb_clk_i (wb_clk_i),
                .rst_n    (rst_n),
                .wb_cyc_i (wb_cyc_i),
                .wb_we_i  (wb_we_i),
                .wb_stb_i (wb_stb_i),
                .wb_adr_i (wb_adr_i),
                .wb_dat_i (wb_dat_i),
                .wb_dat_o (wb_dat_o),
                .wb_ack_o (wb_ack_o),
                .acc      (acc.decode)
        );

        // One register bank and one line engine per channel.
        for (genvar i = 0; i < `I2C_CHANNELS; i++) begin : g_chan
                wire                       start;
                wire [7:0]                 tx_byte;
                wire [`I2C_PRESCALE_W-1:0] prescale;
                wire                       done;
                wire                       ack_bad;

                i2c_channel_regs #(
                        .CHAN_ID (i)
                ) i_i2c_channel_regs (
                        .wb_clk_i (wb_clk_i),
                        .rst_n    (rst_n),
                        .acc      (acc.bank),
                        .start    (start),
                        .tx_byte  (tx_byte),
                        .prescale (prescale),
                        .done     (done),
                        .ack_bad  (ack_bad),
                        .irq_line (wb_int_o[i])
                );

                i2c_byte_engine i_i2c_byte_engine (
                        .wb_clk_i (wb_clk_i),
                        .rst_n    (rst_n),
                        .start    (start),
                        .tx_byte  (tx_byte),
                        .prescale (prescale),
                        .sda_in   (sda_in[i]),
                        .scl      (scl[i]),
                        .sclen    (sclen[i]),
                        .sda_out  (sda_out[i]),
                        .done     (done),
                        .ack_bad  (ack_bad)
                );
        end

endmodule

`default_nettype wire

// File: src/i2c_byte_engine.sv
`default_nettype none
`include "i2c_bank_defs.svh"

module i2c_byte_engine (
        input  wire                        wb_clk_i,
        input  wire                        rst_n,
        input  wire                        start,
        input  wire [7:0]                  tx_byte,
        input  wire [`I2C_PRESCALE_W-1:0]  prescale,
        input  wire                        sda_in,
        output logic                       scl,
        output logic                       sclen,
        output logic                       sda_out,
        output logic                       done,
        output logic                       ack_bad
);

        i2c_line_pkg::engine_state_e state;
        i2c_line_pkg::quarter_t      quarter;
        logic [`I2C_PRESCALE_W-1:0]  presc_q;
        logic [`I2C_PRESCALE_W-1:0]  cnt;
        logic [7:0]                  shift;
        logic [2:0]                  bit_cnt;
        logic                        tick;
        logic                        bit_end;
        logic                        ack_bad_q;

        // A quarter lasts prescale + 1 cycles.
        assign tick    = (cnt == presc_q);
        assign bit_end = tick && (quarter == 2'd3);

        always_ff @(posedge wb_clk_i or negedge rst_n) begin
                if (!rst_n) begin
                        state     <= i2c_line_pkg::ST_IDLE;
                        quarter   <= '0;
                        cnt       <= '0;
                        bit_cnt   <= '0;
                        ack_bad_q <= 1'b0;
                end else begin
                        if (state == i2c_line_pkg::ST_IDLE) begin
                                cnt     <= '0;
                                quarter <= '0;
                        end else if (tick) begin
                                cnt     <= '0;
                                quarter <= quarter + 2'd1;
                        end else begin
                                cnt <= cnt + `I2C_PRESCALE_W'(1);
                        end

                        case (state)
                        i2c_line_pkg::ST_IDLE: begin
                                if (start) begin
                                        state   <= i2c_line_pkg::ST_START;
                                        bit_cnt <= '0;
                                end
                        end
                        i2c_line_pkg::ST_START: begin
                                if (bit_end) begin
                                        state <= i2c_line_pkg::ST_DATA;
                                end
                        end
                        i2c_line_pkg::ST_DATA: begin
                                if (bit_end) begin
                                        bit_cnt <= bit_cnt + 3'd1;
                                        if (bit_cnt == 3'd7) begin
                                                state <= i2c_line_pkg::ST_ACK;
                                        end
                                end
                        end
                        i2c_line_pkg::ST_ACK: begin
                                // Sample as SCL rises into quarter 2.
                                if (tick && quarter == 2'd1) begin
                                        ack_bad_q <= sda_in;
                                end
                                if (bit_end) begin
                                        state <= i2c_line_pkg::ST_STOP;
                                end
                        end
                        i2c_line_pkg::ST_STOP: begin
                                if (bit_end) begin
                                        state <= i2c_line_pkg::ST_IDLE;
                                end
                        end
                        default: state <= i2c_line_pkg::ST_IDLE;
                        endcase
                end
        end

        // Byte and bit rate are fixed for the whole frame.
        always_ff @(posedge wb_clk_i) begin
                if (state == i2c_line_pkg::ST_IDLE && start) begin
                        shift   <= tx_byte;
                        presc_q <= prescale;
                end else if (state == i2c_line_pkg::ST_DATA && bit_end) begin
                        shift <= {shift[6:0], 1'b0};
                end
        end

        always_comb begin
                scl     = quarter[1];
                sda_out = 1'b1;
                case (state)
                i2c_line_pkg::ST_IDLE: scl = 1'b1;
                i2c_line_pkg::ST_START: begin
                        // SDA falls halfway with SCL held high.
                        scl     = 1'b1;
                        sda_out = ~quarter[1];
                end
                i2c_line_pkg::ST_DATA: sda_out = shift[7];
                i2c_line_pkg::ST_ACK:  sda_out = 1'b1;
                i2c_line_pkg::ST_STOP: sda_out = (quarter == 2'd3);
                default: ;
                endcase
        end

        assign sclen   = (state != i2c_line_pkg::ST_IDLE);
        assign done    = (state == i2c_line_pkg::ST_STOP) && bit_end;
        assign ack_bad = ack_bad_q;

endmodule

`default_nettype wire

// File: src/i2c_channel_regs.sv
`default_nettype none
`include "i2c_bank_defs.svh"

module i2c_channel_regs #(
        parameter int CHAN_ID = 0
) (
        input  wire                        wb_clk_i,
        input  wire                        rst_n,
        reg_access_if.bank                 acc,
        output logic                       start,
        output logic [7:0]                 tx_byte,
        output logic [`I2C_PRESCALE_W-1:0] prescale,
        input  wire                        done,
        input  wire                        ack_bad,
        output logic                       irq_line
);

        localparam logic [`I2C_CHAN_W-1:0] OWN_CHAN = CHAN_ID[`I2C_CHAN_W-1:0];

        wb_reg_pkg::ctrl_t     ctrl;
        wb_reg_pkg::status_t   stat;
        logic                  sel;
        logic                  wr_sel;
        logic                  irq_clr;
        logic [`WB_DATA_W-1:0] rd_val;

        assign sel     = (acc.chan == OWN_CHAN);
        assign wr_sel  = acc.wr && sel;
        assign irq_clr = wr_sel && (acc.index == wb_reg_pkg::REG_STATUS) && acc.wdata[2];

        // Go is dropped while busy or disabled.
        assign start = wr_sel && (acc.index == wb_reg_pkg::REG_CMD) && acc.wdata[0]
                       && !stat.busy && ctrl.core_en;

        assign irq_line = stat.irq && ctrl.int_en;

        always_ff @(posedge wb_clk_i or negedge rst_n) begin
                if (!rst_n) begin
                        prescale <= `I2C_PRESCALE_W'(`I2C_PRESCALE_RESET);
                        ctrl     <= '0;
                        tx_byte  <= '0;
                        stat     <= '0;
                end else begin
                        if (wr_sel) begin
                                case (acc.index)
                                wb_reg_pkg::REG_PRESCALE:
                                        prescale <= acc.wdata[`I2C_PRESCALE_W-1:0];
                                wb_reg_pkg::REG_CTRL:
                                        ctrl <= wb_reg_pkg::ctrl_t'(acc.wdata[1:0]);
                                wb_reg_pkg::REG_TXDATA:
                                        tx_byte <= acc.wdata[7:0];
                                default: ;
                                endcase
                        end
                        if (start) begin
                                stat.busy <= 1'b1;
                        end
                        if (irq_clr) begin
                                stat.irq <= 1'b0;
                        end
                        // Frame end wins over a clear in the same cycle.
                        if (done) begin
                                stat.busy <= 1'b0;
                                stat.nack <= ack_bad;
                                stat.irq  <= 1'b1;
                        end
                end
        end

        always_comb begin
                rd_val = '0;
                case (acc.index)
                wb_reg_pkg::REG_PRESCALE: rd_val = `WB_DATA_W'(prescale);
                wb_reg_pkg::REG_CTRL:     rd_val = `WB_DATA_W'(ctrl);
                wb_reg_pkg::REG_TXDATA:   rd_val = `WB_DATA_W'(tx_byte);
                wb_reg_pkg::REG_STATUS:   rd_val = `WB_DATA_W'(stat);
                default: ;
                endcase
        end

        assign acc.rdata[CHAN_ID] = (acc.rd && sel) ? rd_val : '0;

endmodule

`default_nettype wire

// File: src/i2c_line_pkg.sv
`default_nettype none

package i2c_line_pkg;

        // One frame walks these states in order.
        typedef enum logic [2:0] {
                ST_IDLE,
                ST_START,
                ST_DATA,
                ST_ACK,
                ST_STOP
        } engine_state_e;

        // Quarter of a bit period, SCL is high in quarters 2 and 3.
        typedef logic [1:0] quarter_t;

endpackage

`default_nettype wire

// File: src/reg_access_if.sv
`default_nettype none
`include "i2c_bank_defs.svh"

interface reg_access_if;

        logic                       wr;
        logic                       rd;
        logic [`I2C_CHAN_W-1:0]     chan;
        wb_reg_pkg::reg_index_e     index;
        logic [`WB_DATA_W-1:0]      wdata;
        // One read value per channel, zero when not addressed.
        logic [`WB_DATA_W-1:0]      rdata [`I2C_CHANNELS];

        modport decode (
                output wr,
                output rd,
                output chan,
                output index,
                output wdata,
                input  rdata
        );

        modport bank (
                input  wr,
                input  rd,
                input  chan,
                input  index,
                input  wdata,
                output rdata
        );

endinterface

`default_nettype wire

// File: src/wb_reg_pkg.sv
`default_nettype none

package wb_reg_pkg;

        // Register selected by address bits 4 to 2.
        typedef enum logic [2:0] {
                REG_PRESCALE = 3'd0,
                REG_CTRL     = 3'd1,
                REG_TXDATA   = 3'd2,
                REG_CMD      = 3'd3,
                REG_STATUS   = 3'd4
        } reg_index_e;

        typedef struct packed {
                logic int_en;
                logic core_en;
        } ctrl_t;

        // Irq is cleared by writing 1 to bit 2.
        typedef struct packed {
                logic irq;
                logic nack;
                logic busy;
        } status_t;

endpackage

`default_nettype wire

// File: src/wb_slave_decode.sv
`default_nettype none
`include "i2c_bank_defs.svh"

module wb_slave_decode (
        input  wire                     wb_clk_i,
        input  wire                     rst_n,
        input  wire                     wb_cyc_i,
        input  wire                     wb_we_i,
        input  wire [`I2C_CHANNELS-1:0] wb_stb_i,
        input  wire [`WB_ADR_W-1:0]     wb_adr_i,
        input  wire [`WB_DATA_W-1:0]    wb_dat_i,
        output logic [`WB_DATA_W-1:0]   wb_dat_o,
        output logic                    wb_ack_o,
        reg_access_if.decode            acc
);

        logic                   stb_any;
        logic [`I2C_CHAN_W-1:0] stb_chan;
        logic                   pending;
        logic                   req;

        // Lowest strobe index wins.
        always_comb begin
                stb_any  = 1'b0;
                stb_chan = '0;
                for (int i = `I2C_CHANNELS - 1; i >= 0; i--) begin
                        if (wb_stb_i[i]) begin
                                stb_any  = 1'b1;
                                stb_chan = i[`I2C_CHAN_W-1:0];
                        end
                end
        end

        assign req = wb_cyc_i && stb_any && !pending;

        // Pending covers the access and its ack cycle.
        always_ff @(posedge wb_clk_i or negedge rst_n) begin
                if (!rst_n) begin
                        pending  <= 1'b0;
                        acc.wr   <= 1'b0;
                        acc.rd   <= 1'b0;
                        wb_ack_o <= 1'b0;
                end else begin
                        if (req) begin
                                pending <= 1'b1;
                        end else if (wb_ack_o) begin
                                pending <= 1'b0;
                        end
                        acc.wr   <= req && wb_we_i;
                        acc.rd   <= req && !wb_we_i;
                        wb_ack_o <= acc.wr || acc.rd;
                end
        end

        always_ff @(posedge wb_clk_i) begin
                if (req) begin
                        acc.chan  <= stb_chan;
                        acc.index <= wb_reg_pkg::reg_index_e'(wb_adr_i[4:2]);
                        acc.wdata <= wb_dat_i;
                end
                // Read value is taken before the bank updates.
                if (acc.wr || acc.rd) begin
                        wb_dat_o <= acc.rdata[acc.chan];
                end
        end

endmodule

`default_nettype wire

// File: verif/i2c_bank_assert.sv
`default_nettype none
`include "i2c_bank_defs.svh"

module i2c_bank_assert (
        input wire                     wb_clk_i,
        input wire                     rst_n,
        input wire                     wb_cyc_i,
        input wire [`I2C_CHANNELS-1:0] wb_stb_i,
        input wire                     wb_ack_o,
        input wire [`I2C_CHANNELS-1:0] scl,
        input wire [`I2C_CHANNELS-1:0] sclen,
        input wire [`I2C_CHANNELS-1:0] sda_out
);

        // Ack lasts one cycle and follows a request by two edges.
        a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
                wb_ack_o |=> !wb_ack_o)
                else $error("ack held for more than one cycle");

        a_ack_after_req: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
                wb_ack_o |-> $past(wb_cyc_i && (|wb_stb_i), 2))
                else $error("ack without a preceding request");

        a_ack_on_time: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
                $rose(wb_cyc_i && (|wb_stb_i)) |-> ##2 wb_ack_o)
                else $error("ack missing two edges after the request");

        for (genvar i = 0; i < `I2C_CHANNELS; i++) begin : g_line
                logic                   scl_q;
                logic                   sda_q;
                logic                   change_hi;
                i2c_line_pkg::quarter_t hi_edges;

                // SDA moving while SCL stays high.
                assign change_hi = sclen[i] && scl[i] && scl_q && (sda_out[i] != sda_q);

                always_ff @(posedge wb_clk_i or negedge rst_n) begin
                        if (!rst_n) begin
                                scl_q    <= 1'b1;
                                sda_q    <= 1'b1;
                                hi_edges <= '0;
                        end else begin
                                scl_q <= scl[i];
                                sda_q <= sda_out[i];
                                if (!sclen[i]) begin
                                        hi_edges <= '0;
                                end else if (change_hi) begin
                                        hi_edges <= hi_edges + 2'd1;
                                end
                        end
                end

                // Only the start may fall, only the stop may rise.
                a_start_only: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
                        (change_hi && !sda_out[i]) |-> (hi_edges == 2'd0))
                        else $error("SDA fell with SCL high outside a start");

                a_stop_only: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
                        (change_hi && sda_out[i]) |-> (hi_edges == 2'd1))
                        else $error("SDA rose with SCL high outside a stop");
        end

endmodule

`default_nettype wire

// File: verif/i2c_bank_tb.sv
`default_nettype none
`include "i2c_bank_defs.svh"

bind i2c_bank_top i2c_bank_assert i_i2c_bank_assert (.*);

module i2c_bank_tb;

        localparam int N = `I2C_CHANNELS;

        logic                   clk;
        logic                   rst_n;
        logic                   wb_cyc_i;
        logic                   wb_we_i;
        logic [N-1:0]           wb_stb_i;
        logic [`WB_ADR_W-1:0]   wb_adr_i;
        logic [`WB_DATA_W-1:0]  wb_dat_i;
        wire  [`WB_DATA_W-1:0]  wb_dat_o;
        wire                    wb_ack_o;
        wire  [N-1:0]           wb_int_o;
        wire  [N-1:0]           scl;
        wire  [N-1:0]           sclen;
        wire  [N-1:0]           sda_out;
        logic [N-1:0]           sda_in = '1;

        int          errors = 0;
        int          timeouts = 0;
        int          seed = 32'h9edb3179;
        logic [N-1:0] nack_req = '0;
        logic [N-1:0] prev_scl = '1;
        logic [N-1:0] prev_sda = '1;
        int          bit_n [N];
        int          start_cnt [N];
        logic [7:0]  got [N];
        logic [31:0] exp_p [N];
        logic [31:0] exp_c [N];
        logic [31:0] exp_t [N];

        tb_clock_gen i_tb_clock_gen (.clk(clk));

        i2c_bank_top i_i2c_bank_top (.wb_clk_i(clk), .*);

        // Slave model, sampled away from the active clock edge.
        always @(negedge clk) begin
                for (int i = 0; i < N; i++) begin
                        if (sclen[i] && scl[i] && prev_scl[i] && prev_sda[i] && !sda_out[i]) begin
                                start_cnt[i] = start_cnt[i] + 1;
                                bit_n[i] = 0;
                        end else if (sclen[i] && scl[i] && !prev_scl[i]) begin
                                if (bit_n[i] < 8) begin
                                        got[i] = {got[i][6:0], sda_out[i]};
                                end
                                bit_n[i] = bit_n[i] + 1;
                        end
                        sda_in[i] <= (sclen[i] && bit_n[i] == 8) ? nack_req[i] : 1'b1;
                        prev_scl[i] = scl[i];
                        prev_sda[i] = sda_out[i];
                end
        end

        task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
                assert (exp === act)
                else begin
                        $display("[ERROR] %s expected %h got %h", name, exp, act);
                        errors++;
                end
        endtask

        task automatic wb_xfer(input int ch, input logic we, input int idx,
                               input logic [31:0] wdata, output logic [31:0] rdata);
                int n;
                @(posedge clk);
                #1;
                wb_cyc_i = 1'b1;
                wb_we_i  = we;
                wb_stb_i = N'(1) << ch;
                wb_adr_i = `WB_ADR_W'(idx << 2);
                wb_dat_i = wdata;
                for (n = 0; n < 20; n++) begin
                        @(posedge clk);
                        #1;
                        if (wb_ack_o) break;
                end
                if (n == 20) begin
                        $display("Timeout waiting for the bus acknowledge on channel %0d", ch);
                        timeouts++;
                end
                rdata    = wb_dat_o;
                wb_cyc_i = 1'b0;
                wb_stb_i = '0;
        endtask

        task automatic reg_write(input int ch, input int idx, input logic [31:0] wdata);
                logic [31:0] dummy;
                wb_xfer(ch, 1'b1, idx, wdata, dummy);
        endtask

        task automatic reg_expect(input int ch, input int idx, input logic [31:0] exp,
                                  input string name);
                logic [31:0] val;
                wb_xfer(ch, 1'b0, idx, 32'h0, val);
                check_hex($sformatf("ch%0d %s", ch, name), exp, val);
        endtask

        task automatic wait_frame_end(input int ch);
                int n;
                for (n = 0; n < 5000; n++) begin
                        @(posedge clk);
                        #1;
                        if (!sclen[ch]) break;
                end
                if (n == 5000) begin
                        $display("Timeout waiting for the frame on channel %0d to end", ch);
                        timeouts++;
                end
        endtask

        task automatic start_frame(input int ch, input logic [7:0] data, input logic nack);
                nack_req[ch] = nack;
                reg_write(ch, wb_reg_pkg::REG_PRESCALE, 32'd1);
                reg_write(ch, wb_reg_pkg::REG_CTRL, 32'd3);
                reg_write(ch, wb_reg_pkg::REG_TXDATA, {24'h0, data});
                reg_write(ch, wb_reg_pkg::REG_CMD, 32'd1);
        endtask

        initial begin
                int          base;
                logic [7:0]  b0;
                logic [7:0]  b1;
                rst_n    = 1'b0;
                wb_cyc_i = 1'b0;
                wb_we_i  = 1'b0;
                wb_stb_i = '0;
                wb_adr_i = '0;
                wb_dat_i = '0;
                for (int i = 0; i < N; i++) begin
                        bit_n[i] = 0;
                        start_cnt[i] = 0;
                        got[i] = '0;
                end
                repeat (10) @(posedge clk);
                #1;
                rst_n = 1'b1;

                check_hex("wb_ack_o", 32'h0, 32'(wb_ack_o));
                check_hex("wb_int_o", 32'h0, 32'(wb_int_o));
                check_hex("sclen", 32'h0, 32'(sclen));
                check_hex("scl", 32'(N'('1)), 32'(scl));
                check_hex("sda_out", 32'(N'('1)), 32'(sda_out));
                for (int c = 0; c < N; c++) begin
                        reg_expect(c, wb_reg_pkg::REG_PRESCALE, `I2C_PRESCALE_RESET, "prescale");
                        reg_expect(c, wb_reg_pkg::REG_CTRL, 32'h0, "ctrl");
                        reg_expect(c, wb_reg_pkg::REG_TXDATA, 32'h0, "txdata");
                        reg_expect(c, wb_reg_pkg::REG_CMD, 32'h0, "cmd");
                        reg_expect(c, wb_reg_pkg::REG_STATUS, 32'h0, "status");
                end

                // No go is written here, so no frame starts.
                for (int c = 0; c < N; c++) begin
                        exp_p[c] = $random(seed) & 32'hffff;
                        exp_c[c] = $random(seed) & 32'h3;
                        exp_t[c] = $random(seed) & 32'hff;
                        reg_write(c, wb_reg_pkg::REG_PRESCALE, exp_p[c]);
                        reg_write(c, wb_reg_pkg::REG_CTRL, exp_c[c]);
                        reg_write(c, wb_reg_pkg::REG_TXDATA, exp_t[c]);
                end
                for (int c = 0; c < N; c++) begin
                        reg_expect(c, wb_reg_pkg::REG_PRESCALE, exp_p[c], "prescale");
                        reg_expect(c, wb_reg_pkg::REG_CTRL, exp_c[c], "ctrl");
                        reg_expect(c, wb_reg_pkg::REG_TXDATA, exp_t[c], "txdata");
                end

                // Byte frame with ack, then a second go while busy.
                b0 = 8'($random(seed));
                base = start_cnt[0];
                start_frame(0, b0, 1'b0);
                reg_write(0, wb_reg_pkg::REG_CMD, 32'd1);
                wait_frame_end(0);
                check_hex("ch0 slave byte", 32'(b0), 32'(got[0]));
                check_hex("ch0 start count", 32'd1, 32'(start_cnt[0] - base));
                reg_expect(0, wb_reg_pkg::REG_STATUS, 32'h4, "status");
                check_hex("wb_int_o", 32'h1, 32'(wb_int_o));
                reg_write(0, wb_reg_pkg::REG_STATUS, 32'h4);
                reg_expect(0, wb_reg_pkg::REG_STATUS, 32'h0, "status");
                check_hex("wb_int_o", 32'h0, 32'(wb_int_o));

                // Nack frame.
                base = start_cnt[1];
                start_frame(1, 8'h3c, 1'b1);
                reg_write(1, wb_reg_pkg::REG_CMD, 32'd1);
                wait_frame_end(1);
                check_hex("ch1 start count", 32'd1, 32'(start_cnt[1] - base));
                reg_expect(1, wb_reg_pkg::REG_STATUS, 32'h6, "status");
                reg_write(1, wb_reg_pkg::REG_STATUS, 32'h4);

                // Two channels running at the same time.
                b0 = 8'($random(seed));
                b1 = 8'($random(seed));
                start_frame(2, b0, 1'b0);
                start_frame(3, b1, 1'b0);
                wait_frame_end(2);
                wait_frame_end(3);
                check_hex("ch2 slave byte", 32'(b0), 32'(got[2]));
                check_hex("ch3 slave byte", 32'(b1), 32'(got[3]));
                check_hex("wb_int_o", 32'hc, 32'(wb_int_o));

                $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
        output logic clk
);

        // Period of 4 time units.
        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

endmodule

`default_nettype wire
